//--- common/renamePkg.sv
package renamePkg;

    localparam int WIDTH_UOPS = 2;
    localparam int WIDTH_WB = 2;
    localparam int NUM_ARCH = 32;
    localparam int NUM_TAGS = 64;

    typedef logic [4:0] ArchReg;
    typedef logic [5:0] PhysTag;

    // Wraps around, order by signed difference
    typedef logic [6:0] SqN;

    typedef enum logic [2:0] {
        INT,
        MUL,
        DIV,
        LSU,
        ST,
        RN
    } FuType;

    typedef struct packed {
        logic isImm;
        PhysTag tag;
    } PhysView;

    // RN ops carry a small constant in place of a register
    typedef struct packed {
        logic isImm;
        logic [5:0] value;
    } ImmView;

    typedef union packed {
        PhysView phys;
        ImmView imm;
    } TagWord;

    typedef struct packed {
        logic valid;
        ArchReg rd;
        ArchReg rs0;
        ArchReg rs1;
        FuType fu;
        logic [31:0] imm;
        logic [5:0] opcode;
    } DecUop;

    typedef struct packed {
        logic [31:0] imm;
        logic [5:0] opcode;
        FuType fu;
        ArchReg rd;
        TagWord tagA;
        TagWord tagB;
        TagWord tagDst;
        logic availA;
        logic availB;
        SqN sqN;
        SqN loadSqN;
        SqN storeSqN;
    } RenUop;

    typedef struct packed {
        logic valid;
        ArchReg rd;
        PhysTag tagDst;
        SqN sqN;
    } ComUop;

    typedef struct packed {
        logic valid;
        PhysTag tagDst;
    } WbRes;

    typedef struct packed {
        logic taken;
        SqN sqN;
        SqN loadSqN;
        SqN storeSqN;
    } BranchInfo;

endpackage

//--- logic/seqCounter.sv
module seqCounter import renamePkg::*; (
    input logic clk,
    input logic rst,
    input BranchInfo branch,
    input DecUop uops [WIDTH_UOPS],
    input logic accept,
    output SqN slotSqN [WIDTH_UOPS],
    output SqN slotLoadSqN [WIDTH_UOPS],
    output SqN slotStoreSqN [WIDTH_UOPS],
    output logic slotOrder [WIDTH_UOPS],
    output SqN nextSqN,
    output SqN nextLoadSqN,
    output SqN nextStoreSqN
);

    SqN cntSqN;
    SqN cntLoad;
    SqN cntStore;
    logic order;
    SqN endSqN;
    SqN endLoad;
    SqN endStore;
    logic endOrder;

    always_comb begin
        endSqN = cntSqN;
        endLoad = cntLoad;
        endStore = cntStore;
        endOrder = order;
        for (int i = 0; i < WIDTH_UOPS; i++) begin
            slotSqN[i] = endSqN;
            slotLoadSqN[i] = endLoad;
            slotOrder[i] = endOrder;
            if (uops[i].valid) begin
                endSqN = endSqN + 1'b1;
                case (uops[i].fu)
                    INT: endOrder = !endOrder;
                    DIV: endOrder = 1'b1;
                    MUL: endOrder = 1'b0;
                    LSU: endLoad = endLoad + 1'b1;
                    ST: endStore = endStore + 1'b1;
                    default: ;
                endcase
            end
            // Stores count before taking their number
            slotStoreSqN[i] = endStore;
        end
    end

    assign nextSqN = cntSqN;
    assign nextLoadSqN = cntLoad;
    assign nextStoreSqN = cntStore + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            cntSqN <= '0;
            cntLoad <= '0;
            cntStore <= '1;
            order <= 1'b0;
        end else if (branch.taken) begin
            cntSqN <= branch.sqN + 1'b1;
            cntLoad <= branch.loadSqN;
            cntStore <= branch.storeSqN;
        end else if (accept) begin
            cntSqN <= endSqN;
            cntLoad <= endLoad;
            cntStore <= endStore;
            order <= endOrder;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(accept && branch.taken));

endmodule

//--- rename/renameTable.sv
module renameTable import renamePkg::*; (
    input logic clk,
    input logic rst,
    input logic recover,

    input ArchReg lookupRegs [2*WIDTH_UOPS],
    output TagWord lookupTags [2*WIDTH_UOPS],
    output logic lookupAvail [2*WIDTH_UOPS],

    input logic issueValid [WIDTH_UOPS],
    input ArchReg issueRegs [WIDTH_UOPS],
    input TagWord issueTags [WIDTH_UOPS],

    input logic commitValid [WIDTH_UOPS],
    input ArchReg commitRegs [WIDTH_UOPS],
    input PhysTag commitTags [WIDTH_UOPS],
    output PhysTag commitPrevTags [WIDTH_UOPS],
    // Tags held by the committed map after this cycle's commits
    output logic [NUM_TAGS-1:0] committedMap,

    input WbRes wb [WIDTH_WB]
);

    TagWord specMap [NUM_ARCH];
    PhysTag comMap [NUM_ARCH];
    PhysTag comMapNext [NUM_ARCH];
    logic [NUM_TAGS-1:0] ready;

    always_comb begin
        for (int l = 0; l < 2*WIDTH_UOPS; l++) begin
            lookupTags[l] = specMap[lookupRegs[l]];
            // Immediates are always available
            lookupAvail[l] = lookupTags[l].phys.isImm || ready[lookupTags[l].phys.tag];
            for (int k = 0; k < WIDTH_WB; k++) begin
                if (wb[k].valid && lookupTags[l] == {1'b0, wb[k].tagDst})
                    lookupAvail[l] = 1'b1;
            end
            // Earlier slots of the same group override the table
            for (int j = 0; j < l / 2; j++) begin
                if (issueValid[j] && issueRegs[j] == lookupRegs[l]) begin
                    lookupTags[l] = issueTags[j];
                    lookupAvail[l] = issueTags[j].phys.isImm;
                end
            end
        end
    end

    always_comb begin
        comMapNext = comMap;
        for (int i = 0; i < WIDTH_UOPS; i++) begin
            commitPrevTags[i] = comMapNext[commitRegs[i]];
            if (commitValid[i])
                comMapNext[commitRegs[i]] = commitTags[i];
        end
        committedMap = '0;
        for (int r = 0; r < NUM_ARCH; r++)
            committedMap[comMapNext[r]] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_ARCH; r++) begin
                specMap[r] <= {1'b0, PhysTag'(r)};
                comMap[r] <= PhysTag'(r);
            end
            ready <= {{(NUM_TAGS-NUM_ARCH){1'b0}}, {NUM_ARCH{1'b1}}};
        end else begin
            comMap <= comMapNext;
            if (recover) begin
                for (int r = 0; r < NUM_ARCH; r++)
                    specMap[r] <= {1'b0, comMapNext[r]};
            end else begin
                for (int i = 0; i < WIDTH_UOPS; i++) begin
                    if (issueValid[i]) begin
                        specMap[issueRegs[i]] <= issueTags[i];
                        if (!issueTags[i].phys.isImm)
                            ready[issueTags[i].phys.tag] <= 1'b0;
                    end
                end
            end
            for (int k = 0; k < WIDTH_WB; k++) begin
                if (wb[k].valid)
                    ready[wb[k].tagDst] <= 1'b1;
            end
        end
    end

    for (genvar i = 0; i < WIDTH_UOPS; i++) begin : gIssueChk
        assert property (@(posedge clk) disable iff (rst) issueValid[i] |-> issueRegs[i] != '0);
    end

endmodule

//--- rename/tagBuffer.sv
module tagBuffer import renamePkg::*; (
    input logic clk,
    input logic rst,
    input logic recover,

    input logic req [WIDTH_UOPS],
    output PhysTag allocTags [WIDTH_UOPS],
    output logic allocValid [WIDTH_UOPS],

    input logic commitValid [WIDTH_UOPS],
    input PhysTag commitPrevTags [WIDTH_UOPS],
    input logic [NUM_TAGS-1:0] committedMap
);

    logic [NUM_TAGS-1:0] freeBits;
    logic grant;

    // Lowest free tags in slot order
    // A requesting slot hides its tag from later slots
    always_comb begin
        logic [NUM_TAGS-1:0] avail;
        avail = freeBits;
        grant = 1'b1;
        for (int i = 0; i < WIDTH_UOPS; i++) begin
            allocValid[i] = 1'b0;
            allocTags[i] = '0;
            for (int t = NUM_TAGS - 1; t >= 0; t--) begin
                if (avail[t]) begin
                    allocValid[i] = 1'b1;
                    allocTags[i] = PhysTag'(t);
                end
            end
            if (req[i] && allocValid[i])
                avail[allocTags[i]] = 1'b0;
            // A starved slot stalls the whole group
            if (req[i] && !allocValid[i])
                grant = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        logic [NUM_TAGS-1:0] nextFree;
        if (rst) begin
            freeBits <= {{(NUM_TAGS-NUM_ARCH){1'b1}}, {NUM_ARCH{1'b0}}};
        end else if (recover) begin
            freeBits <= ~committedMap;
        end else begin
            nextFree = freeBits;
            for (int i = 0; i < WIDTH_UOPS; i++) begin
                if (grant && req[i])
                    nextFree[allocTags[i]] = 1'b0;
            end
            for (int i = 0; i < WIDTH_UOPS; i++) begin
                if (commitValid[i])
                    nextFree[commitPrevTags[i]] = 1'b1;
            end
            freeBits <= nextFree;
        end
    end

    for (genvar i = 0; i < WIDTH_UOPS; i++) begin : gPoolChk
        assert property (@(posedge clk) disable iff (rst)
            (grant && req[i]) |-> freeBits[allocTags[i]]);
        assert property (@(posedge clk) disable iff (rst)
            commitValid[i] |-> !freeBits[commitPrevTags[i]]);
    end

endmodule

//--- rename/renameStage.sv
module renameStage import renamePkg::*; (
    input logic clk,
    input logic rst,
    input logic en,
    input logic frontEn,

    input DecUop decUops [WIDTH_UOPS],
    input ComUop comUops [WIDTH_UOPS],
    input WbRes wbRes [WIDTH_WB],
    input BranchInfo branch,

    output logic uopValid [WIDTH_UOPS],
    output RenUop renUops [WIDTH_UOPS],
    // Alternating bit for spreading int ops over two issue queues
    output logic uopOrdering [WIDTH_UOPS],
    output SqN nextSqN,
    output SqN nextLoadSqN,
    output SqN nextStoreSqN,
    output logic stall
);

    logic eligible;
    logic accept;
    logic hold;
    logic needTag [WIDTH_UOPS];
    logic tagReq [WIDTH_UOPS];

    ArchReg lookupRegs [2*WIDTH_UOPS];
    TagWord lookupTags [2*WIDTH_UOPS];
    logic lookupAvail [2*WIDTH_UOPS];

    logic issueValid [WIDTH_UOPS];
    ArchReg issueRegs [WIDTH_UOPS];
    TagWord dstTags [WIDTH_UOPS];

    logic commitValid [WIDTH_UOPS];
    ArchReg commitRegs [WIDTH_UOPS];
    PhysTag commitTags [WIDTH_UOPS];
    PhysTag commitPrevTags [WIDTH_UOPS];
    logic [NUM_TAGS-1:0] committedMap;

    PhysTag allocTags [WIDTH_UOPS];
    logic allocValid [WIDTH_UOPS];

    SqN slotSqN [WIDTH_UOPS];
    SqN slotLoadSqN [WIDTH_UOPS];
    SqN slotStoreSqN [WIDTH_UOPS];
    logic slotOrder [WIDTH_UOPS];

    // Tag requests are not gated by stall, the pool only grants whole groups
    always_comb begin
        eligible = en && frontEn && !branch.taken;
        stall = 1'b0;
        for (int i = 0; i < WIDTH_UOPS; i++) begin
            needTag[i] = decUops[i].valid && decUops[i].rd != '0 && decUops[i].fu != RN;
            tagReq[i] = eligible && needTag[i];
            if (needTag[i] && !allocValid[i])
                stall = 1'b1;
        end
        accept = eligible && !stall;
        hold = en && (!frontEn || stall) && !branch.taken;
    end

    always_comb begin
        for (int i = 0; i < WIDTH_UOPS; i++) begin
            lookupRegs[2*i] = decUops[i].rs0;
            lookupRegs[2*i+1] = decUops[i].rs1;
            issueValid[i] = accept && decUops[i].valid && decUops[i].rd != '0;
            issueRegs[i] = decUops[i].rd;

            if (decUops[i].fu == RN) begin
                dstTags[i].imm.isImm = 1'b1;
                dstTags[i].imm.value = decUops[i].imm[5:0];
            end else begin
                // Register zero keeps tag zero
                dstTags[i].phys.isImm = 1'b0;
                dstTags[i].phys.tag = needTag[i] ? allocTags[i] : '0;
            end

            // Commits younger than a taken branch are dropped
            commitValid[i] = comUops[i].valid && comUops[i].rd != '0
                && (!branch.taken || $signed(SqN'(comUops[i].sqN - branch.sqN)) <= 0);
            commitRegs[i] = comUops[i].rd;
            commitTags[i] = comUops[i].tagDst;
        end
    end

    renameTable i_renameTable (
        .clk(clk),
        .rst(rst),
        .recover(branch.taken),
        .lookupRegs(lookupRegs),
        .lookupTags(lookupTags),
        .lookupAvail(lookupAvail),
        .issueValid(issueValid),
        .issueRegs(issueRegs),
        .issueTags(dstTags),
        .commitValid(commitValid),
        .commitRegs(commitRegs),
        .commitTags(commitTags),
        .commitPrevTags(commitPrevTags),
        .committedMap(committedMap),
        .wb(wbRes)
    );

    tagBuffer i_tagBuffer (
        .clk(clk),
        .rst(rst),
        .recover(branch.taken),
        .req(tagReq),
        .allocTags(allocTags),
        .allocValid(allocValid),
        .commitValid(commitValid),
        .commitPrevTags(commitPrevTags),
        .committedMap(committedMap)
    );

    seqCounter i_seqCounter (
        .clk(clk),
        .rst(rst),
        .branch(branch),
        .uops(decUops),
        .accept(accept),
        .slotSqN(slotSqN),
        .slotLoadSqN(slotLoadSqN),
        .slotStoreSqN(slotStoreSqN),
        .slotOrder(slotOrder),
        .nextSqN(nextSqN),
        .nextLoadSqN(nextLoadSqN),
        .nextStoreSqN(nextStoreSqN)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < WIDTH_UOPS; i++) begin
                uopValid[i] <= 1'b0;
                uopOrdering[i] <= 1'b0;
            end
        end else if (branch.taken || !en) begin
            for (int i = 0; i < WIDTH_UOPS; i++)
                uopValid[i] <= 1'b0;
        end else if (accept) begin
            for (int i = 0; i < WIDTH_UOPS; i++) begin
                uopValid[i] <= decUops[i].valid;
                uopOrdering[i] <= slotOrder[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < WIDTH_UOPS; i++) begin
                renUops[i].imm <= decUops[i].imm;
                renUops[i].opcode <= decUops[i].opcode;
                renUops[i].fu <= decUops[i].fu;
                renUops[i].rd <= decUops[i].rd;
                renUops[i].tagA <= lookupTags[2*i];
                renUops[i].tagB <= lookupTags[2*i+1];
                renUops[i].availA <= lookupAvail[2*i];
                renUops[i].availB <= lookupAvail[2*i+1];
                renUops[i].tagDst <= dstTags[i];
                renUops[i].sqN <= slotSqN[i];
                renUops[i].loadSqN <= slotLoadSqN[i];
                renUops[i].storeSqN <= slotStoreSqN[i];
            end
        end else if (hold) begin
            // Held operands still pick up results, they are read later
            for (int k = 0; k < WIDTH_WB; k++) begin
                for (int i = 0; i < WIDTH_UOPS; i++) begin
                    if (wbRes[k].valid && uopValid[i]) begin
                        if (renUops[i].tagA == {1'b0, wbRes[k].tagDst})
                            renUops[i].availA <= 1'b1;
                        if (renUops[i].tagB == {1'b0, wbRes[k].tagDst})
                            renUops[i].availB <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- tb/renameStageTb.sv
module renameStageTb import renamePkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic clk;
    logic rst;
    logic en;
    logic frontEn;
    DecUop decUops [WIDTH_UOPS];
    ComUop comUops [WIDTH_UOPS];
    WbRes wbRes [WIDTH_WB];
    BranchInfo branch;
    logic uopValid [WIDTH_UOPS];
    RenUop renUops [WIDTH_UOPS];
    logic uopOrdering [WIDTH_UOPS];
    SqN nextSqN;
    SqN nextLoadSqN;
    SqN nextStoreSqN;
    logic stall;

    // Reference model state
    TagWord mSpec [NUM_ARCH];
    PhysTag mCom [NUM_ARCH];
    logic [NUM_TAGS-1:0] mReady;
    logic [NUM_TAGS-1:0] mFree;
    SqN mSqN;
    SqN mLoad;
    SqN mStore;
    logic mOrder;
    logic expValid [WIDTH_UOPS];
    logic expOrd [WIDTH_UOPS];
    RenUop expUop [WIDTH_UOPS];
    logic lastAccept;
    logic sawStall;
    logic sawAccept;

    // Renamed ops still to commit, tags still to write back
    ComUop comQ [$];
    PhysTag wbQ [$];

    renameStage i_renameStage (
        .clk(clk),
        .rst(rst),
        .en(en),
        .frontEn(frontEn),
        .decUops(decUops),
        .comUops(comUops),
        .wbRes(wbRes),
        .branch(branch),
        .uopValid(uopValid),
        .renUops(renUops),
        .uopOrdering(uopOrdering),
        .nextSqN(nextSqN),
        .nextLoadSqN(nextLoadSqN),
        .nextStoreSqN(nextStoreSqN),
        .stall(stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic expectEq(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("Timed out at %0t waiting for %s", $time, what);
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
    endtask

    function automatic void resetModel();
        mReady = '0;
        mFree = '0;
        for (int r = 0; r < NUM_ARCH; r++) begin
            mSpec[r] = {1'b0, PhysTag'(r)};
            mCom[r] = PhysTag'(r);
            mReady[r] = 1'b1;
        end
        for (int t = NUM_ARCH; t < NUM_TAGS; t++)
            mFree[t] = 1'b1;
        mSqN = '0;
        mLoad = '0;
        mStore = '1;
        mOrder = 1'b0;
        lastAccept = 1'b0;
        for (int i = 0; i < WIDTH_UOPS; i++) begin
            expValid[i] = 1'b0;
            expOrd[i] = 1'b0;
        end
    endfunction

    // One clock edge of the stage, returns the stall level seen before it
    function automatic logic renameRef();
        logic eligible;
        logic accept;
        logic hold;
        logic stallExp;
        logic need [WIDTH_UOPS];
        logic issue [WIDTH_UOPS];
        logic found [WIDTH_UOPS];
        PhysTag alloc [WIDTH_UOPS];
        TagWord dst [WIDTH_UOPS];
        logic slotOrd [WIDTH_UOPS];
        RenUop u [WIDTH_UOPS];
        logic [NUM_TAGS-1:0] pool;
        PhysTag comNext [NUM_ARCH];
        logic comOk [WIDTH_UOPS];
        PhysTag prevTag [WIDTH_UOPS];
        ArchReg src;
        TagWord t;
        logic av;
        SqN age;
        SqN sq;
        SqN ld;
        SqN stc;
        logic ord;

        eligible = en && frontEn && !branch.taken;
        pool = mFree;
        stallExp = 1'b0;
        for (int i = 0; i < WIDTH_UOPS; i++) begin
            need[i] = decUops[i].valid && decUops[i].rd != '0 && decUops[i].fu != RN;
            found[i] = 1'b0;
            alloc[i] = '0;
            for (int k = 0; k < NUM_TAGS && !found[i]; k++) begin
                if (pool[k]) begin
                    found[i] = 1'b1;
                    alloc[i] = PhysTag'(k);
                end
            end
            if (eligible && need[i] && found[i])
                pool[alloc[i]] = 1'b0;
            if (need[i] && !found[i])
                stallExp = 1'b1;
        end
        accept = eligible && !stallExp;
        hold = en && (!frontEn || stallExp) && !branch.taken;

        // Commits in slot order, younger than a taken branch are dropped
        comNext = mCom;
        for (int i = 0; i < WIDTH_UOPS; i++) begin
            age = comUops[i].sqN - branch.sqN;
            comOk[i] = comUops[i].valid && comUops[i].rd != '0
                && (!branch.taken || age == '0 || age[6]);
            prevTag[i] = comNext[comUops[i].rd];
            if (comOk[i])
                comNext[comUops[i].rd] = comUops[i].tagDst;
        end

        sq = mSqN;
        ld = mLoad;
        stc = mStore;
        ord = mOrder;
        for (int i = 0; i < WIDTH_UOPS; i++) begin
            issue[i] = accept && decUops[i].valid && decUops[i].rd != '0;
            if (decUops[i].fu == RN)
                dst[i] = {1'b1, decUops[i].imm[5:0]};
            else
                dst[i] = {1'b0, need[i] ? alloc[i] : 6'd0};
            for (int s = 0; s < 2; s++) begin
                src = (s == 0) ? decUops[i].rs0 : decUops[i].rs1;
                t = mSpec[src];
                av = t.imm.isImm || mReady[t.phys.tag];
                for (int k = 0; k < WIDTH_WB; k++) begin
                    if (wbRes[k].valid && !t.phys.isImm && t.phys.tag == wbRes[k].tagDst)
                        av = 1'b1;
                end
                // Producer in an earlier slot of this group
                for (int j = 0; j < i; j++) begin
                    if (issue[j] && decUops[j].rd == src) begin
                        t = dst[j];
                        av = dst[j].imm.isImm;
                    end
                end
                if (s == 0) begin
                    u[i].tagA = t;
                    u[i].availA = av;
                end else begin
                    u[i].tagB = t;
                    u[i].availB = av;
                end
            end
            u[i].imm = decUops[i].imm;
            u[i].opcode = decUops[i].opcode;
            u[i].fu = decUops[i].fu;
            u[i].rd = decUops[i].rd;
            u[i].tagDst = dst[i];
            u[i].sqN = sq;
            u[i].loadSqN = ld;
            slotOrd[i] = ord;
            if (decUops[i].valid) begin
                sq = sq + 1'b1;
                case (decUops[i].fu)
                    INT: ord = !ord;
                    DIV: ord = 1'b1;
                    MUL: ord = 1'b0;
                    LSU: ld = ld + 1'b1;
                    ST: stc = stc + 1'b1;
                    default: ;
                endcase
            end
            u[i].storeSqN = stc;
        end

        // Output register
        for (int i = 0; i < WIDTH_UOPS; i++) begin
            if (branch.taken || !en) begin
                expValid[i] = 1'b0;
            end else if (accept) begin
                expValid[i] = decUops[i].valid;
                expOrd[i] = slotOrd[i];
                expUop[i] = u[i];
            end else if (hold && expValid[i]) begin
                for (int k = 0; k < WIDTH_WB; k++) begin
                    if (wbRes[k].valid && expUop[i].tagA == {1'b0, wbRes[k].tagDst})
                        expUop[i].availA = 1'b1;
                    if (wbRes[k].valid && expUop[i].tagB == {1'b0, wbRes[k].tagDst})
                        expUop[i].availB = 1'b1;
                end
            end
        end

        // Maps, ready bits and free set
        if (branch.taken) begin
            mFree = '1;
            for (int r = 0; r < NUM_ARCH; r++) begin
                mSpec[r] = {1'b0, comNext[r]};
                mFree[comNext[r]] = 1'b0;
            end
        end else begin
            for (int i = 0; i < WIDTH_UOPS; i++) begin
                if (issue[i]) begin
                    mSpec[decUops[i].rd] = dst[i];
                    if (!dst[i].phys.isImm)
                        mReady[dst[i].phys.tag] = 1'b0;
                end
                if (accept && need[i])
                    mFree[alloc[i]] = 1'b0;
            end
            for (int i = 0; i < WIDTH_UOPS; i++) begin
                if (comOk[i])
                    mFree[prevTag[i]] = 1'b1;
            end
        end
        for (int k = 0; k < WIDTH_WB; k++) begin
            if (wbRes[k].valid)
                mReady[wbRes[k].tagDst] = 1'b1;
        end
        mCom = comNext;

        if (branch.taken) begin
            mSqN = branch.sqN + 1'b1;
            mLoad = branch.loadSqN;
            mStore = branch.storeSqN;
        end else if (accept) begin
            mSqN = sq;
            mLoad = ld;
            mStore = stc;
            mOrder = ord;
        end
        lastAccept = accept;
        return stallExp;
    endfunction

    // Compare outputs registered on the previous edge, then step the model
    always @(posedge clk) begin
        logic expStall;
        ComUop c;
        if (rst) begin
            resetModel();
        end else begin
            for (int i = 0; i < WIDTH_UOPS; i++) begin
                expectEq($sformatf("uopValid[%0d]", i), 128'(uopValid[i]), 128'(expValid[i]));
                if (expValid[i]) begin
                    expectEq($sformatf("renUops[%0d].tagA", i),
                        128'(renUops[i].tagA), 128'(expUop[i].tagA));
                    expectEq($sformatf("renUops[%0d].availA", i),
                        128'(renUops[i].availA), 128'(expUop[i].availA));
                    expectEq($sformatf("renUops[%0d].tagB", i),
                        128'(renUops[i].tagB), 128'(expUop[i].tagB));
                    expectEq($sformatf("renUops[%0d].availB", i),
                        128'(renUops[i].availB), 128'(expUop[i].availB));
                    expectEq($sformatf("renUops[%0d].tagDst", i),
                        128'(renUops[i].tagDst), 128'(expUop[i].tagDst));
                    expectEq($sformatf("renUops[%0d]", i), 128'(renUops[i]), 128'(expUop[i]));
                    expectEq($sformatf("uopOrdering[%0d]", i),
                        128'(uopOrdering[i]), 128'(expOrd[i]));
                end
            end
            expectEq("nextSqN", 128'(nextSqN), 128'(mSqN));
            expectEq("nextLoadSqN", 128'(nextLoadSqN), 128'(mLoad));
            expectEq("nextStoreSqN", 128'(nextStoreSqN), 128'(SqN'(mStore + 1'b1)));
            expStall = renameRef();
            expectEq("stall", 128'(stall), 128'(expStall));
            if (expStall)
                sawStall = 1'b1;
            if (lastAccept) begin
                sawAccept = 1'b1;
                for (int i = 0; i < WIDTH_UOPS; i++) begin
                    if (expValid[i] && expUop[i].rd != '0 && expUop[i].fu != RN) begin
                        c.valid = 1'b1;
                        c.rd = expUop[i].rd;
                        c.tagDst = expUop[i].tagDst.phys.tag;
                        c.sqN = expUop[i].sqN;
                        comQ.push_back(c);
                        wbQ.push_back(c.tagDst);
                    end
                end
            end
        end
    end

    task automatic setIdle();
        en = 1'b1;
        frontEn = 1'b1;
        branch = '0;
        for (int i = 0; i < WIDTH_UOPS; i++) begin
            decUops[i] = '0;
            comUops[i] = '0;
        end
        for (int k = 0; k < WIDTH_WB; k++)
            wbRes[k] = '0;
    endtask

    task automatic driveRandom(input bit doCommit, input bit doBranch, input bit needTags);
        int n;
        en = needTags || ($urandom_range(0, 15) != 0);
        frontEn = needTags || ($urandom_range(0, 5) != 0);
        for (int i = 0; i < WIDTH_UOPS; i++) begin
            decUops[i].valid = needTags || ($urandom_range(0, 7) != 0);
            decUops[i].rd = ArchReg'(needTags ? $urandom_range(1, 31) : $urandom_range(0, 7));
            decUops[i].rs0 = ArchReg'($urandom_range(0, 7));
            decUops[i].rs1 = ArchReg'($urandom_range(0, 7));
            decUops[i].fu = needTags ? INT : FuType'(3'($urandom_range(0, 5)));
            decUops[i].imm = $urandom();
            decUops[i].opcode = 6'($urandom());
            comUops[i] = '0;
            if (doCommit && comQ.size() > 0 && $urandom_range(0, 3) != 0)
                comUops[i] = comQ.pop_front();
        end
        for (int k = 0; k < WIDTH_WB; k++) begin
            wbRes[k] = '0;
            if (wbQ.size() > 0 && $urandom_range(0, 1) != 0) begin
                n = $urandom_range(0, wbQ.size() - 1);
                wbRes[k].valid = 1'b1;
                wbRes[k].tagDst = wbQ[n];
                wbQ.delete(n);
            end
        end
        branch = '0;
        if (doBranch && $urandom_range(0, 11) == 0) begin
            branch.taken = 1'b1;
            branch.sqN = mSqN - 1'b1;
            // Sometimes the second commit is younger than the branch
            if (comUops[0].valid && comUops[1].valid && $urandom_range(0, 1) != 0)
                branch.sqN = comUops[0].sqN;
            branch.loadSqN = SqN'($urandom());
            branch.storeSqN = SqN'($urandom());
            comQ.delete();
            wbQ.delete();
        end
    endtask

    initial begin
        int n;
        SqN bSq;
        void'($urandom(32'h7047f912));
        clk = 1'b0;
        rst = 1'b1;
        sawStall = 1'b0;
        sawAccept = 1'b0;
        setIdle();
        en = 1'b0;
        frontEn = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        en = 1'b1;
        frontEn = 1'b1;

        // First group, slot 1 reads what slot 0 writes
        decUops[0] = '{valid: 1'b1, rd: 5'd5, rs0: 5'd1, rs1: 5'd2, fu: INT,
                       imm: 32'd0, opcode: 6'd0};
        decUops[1] = '{valid: 1'b1, rd: 5'd6, rs0: 5'd5, rs1: 5'd3, fu: INT,
                       imm: 32'd0, opcode: 6'd0};
        for (n = 0; n < 20 && !uopValid[0]; n++)
            @(negedge clk);
        if (!uopValid[0])
            timeoutFail("the first renamed group");
        setIdle();
        expectEq("renUops[0].sqN", 128'(renUops[0].sqN), 128'(0));
        expectEq("renUops[1].sqN", 128'(renUops[1].sqN), 128'(1));
        expectEq("renUops[0].tagA", 128'(renUops[0].tagA), 128'(7'd1));
        expectEq("renUops[0].availA", 128'(renUops[0].availA), 128'(1));
        expectEq("renUops[0].tagB", 128'(renUops[0].tagB), 128'(7'd2));
        expectEq("renUops[0].tagDst", 128'(renUops[0].tagDst), 128'(7'd32));
        expectEq("renUops[1].tagA", 128'(renUops[1].tagA), 128'(7'd32));
        expectEq("renUops[1].availA", 128'(renUops[1].availA), 128'(0));
        expectEq("renUops[1].tagB", 128'(renUops[1].tagB), 128'(7'd3));
        expectEq("renUops[1].tagDst", 128'(renUops[1].tagDst), 128'(7'd33));

        // Random mixes with commits and writebacks
        repeat (400) begin
            @(negedge clk);
            driveRandom(1'b1, 1'b0, 1'b0);
        end

        // Withhold commits until the pool runs dry
        sawStall = 1'b0;
        for (n = 0; n < 100 && !sawStall; n++) begin
            @(negedge clk);
            driveRandom(1'b0, 1'b0, 1'b1);
        end
        if (!sawStall)
            timeoutFail("stall with commits withheld");
        @(negedge clk);
        sawAccept = 1'b0;
        for (n = 0; n < 100 && !sawAccept; n++) begin
            driveRandom(1'b1, 1'b0, 1'b1);
            @(negedge clk);
        end
        if (!sawAccept)
            timeoutFail("renaming to resume after commits");

        // Branch recovery mixed in
        repeat (400) begin
            @(negedge clk);
            driveRandom(1'b1, 1'b1, 1'b0);
        end

        @(negedge clk);
        setIdle();
        bSq = SqN'($urandom());
        branch.taken = 1'b1;
        branch.sqN = bSq;
        branch.loadSqN = SqN'($urandom());
        branch.storeSqN = SqN'($urandom());
        comQ.delete();
        wbQ.delete();
        @(negedge clk);
        branch = '0;
        expectEq("uopValid[0] after branch", 128'(uopValid[0]), 128'(0));
        expectEq("uopValid[1] after branch", 128'(uopValid[1]), 128'(0));
        expectEq("nextSqN after branch", 128'(nextSqN), 128'(SqN'(bSq + 1'b1)));
        repeat (20) begin
            @(negedge clk);
            driveRandom(1'b1, 1'b0, 1'b0);
        end
        @(negedge clk);
        setIdle();
        @(negedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- renameStage.f
common/renamePkg.sv
logic/seqCounter.sv
rename/renameTable.sv
rename/tagBuffer.sv
rename/renameStage.sv
tb/renameStageTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= renameStageTb
FILELIST ?= renameStage.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
